// ==== source/lcd_pkg.sv ====
package lcd_pkg;

	// clock and counter sizing
	localparam int CLK_MHZ = 30;                            // cycles per microsecond
	localparam int CNT_W   = 14;

	typedef logic [CNT_W-1:0] cyc_t;                        // timing counter value
	typedef logic [7:0]       lcd_byte_t;                   // byte on the lcd bus
	typedef logic [6:0]       lcd_cfg_t;                    // configuration word

	// delays in clock cycles
	localparam cyc_t POWER_UP_CYC = cyc_t'(500 * CLK_MHZ);
	localparam cyc_t E_SETUP_CYC  = cyc_t'(1 * CLK_MHZ);    // start of cycle to rise of e
	localparam cyc_t E_HIGH_CYC   = cyc_t'(13 * CLK_MHZ);
	localparam cyc_t CMD_CYC      = cyc_t'(50 * CLK_MHZ);   // host transaction
	localparam cyc_t FSET_CYC     = cyc_t'(60 * CLK_MHZ);
	localparam cyc_t DISP_CYC     = cyc_t'(60 * CLK_MHZ);
	localparam cyc_t CLEAR_CYC    = cyc_t'(210 * CLK_MHZ);  // clear needs the longest wait
	localparam cyc_t ENTRY_CYC    = cyc_t'(110 * CLK_MHZ);

	// bit positions in lcd_cfg_t
	localparam int CFG_LINES = 6;
	localparam int CFG_FONT  = 5;
	localparam int CFG_DISP  = 4;
	localparam int CFG_CURS  = 3;
	localparam int CFG_BLINK = 2;
	localparam int CFG_INC   = 1;
	localparam int CFG_SHIFT = 0;

	typedef enum logic [2:0] {
		INIT_POWER = 3'd0,
		INIT_FSET  = 3'd1,
		INIT_DISP  = 3'd2,
		INIT_CLEAR = 3'd3,
		INIT_ENTRY = 3'd4,
		INIT_DONE  = 3'd5
	} init_step_t;

	typedef enum logic [1:0] {
		ST_INIT  = 2'd0,
		ST_READY = 2'd1,
		ST_XFER  = 2'd2
	} ctrl_state_t;

endpackage

// ==== source/lcd_bus_cycle.sv ====
`timescale 1ns/1ps

module lcd_bus_cycle (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               rs_in,
	input  logic               rw_in,
	input  lcd_pkg::lcd_byte_t data_in,
	input  lcd_pkg::cyc_t      dur,
	output logic               e,
	output logic               rs,
	output logic               rw,
	output lcd_pkg::lcd_byte_t lcd_data,
	output logic               done
);

	logic          active;      // cycle in progress
	lcd_pkg::cyc_t cnt;         // cycles since start of bus cycle
	lcd_pkg::cyc_t cnt_nxt;
	lcd_pkg::cyc_t dur_q;       // total length of current cycle
	logic          e_window;

	assign cnt_nxt = cnt + lcd_pkg::cyc_t'(1);

	// last cycle of the pin window
	assign done = active && (cnt_nxt == dur_q);

	// e high from E_SETUP_CYC for E_HIGH_CYC cycles
	assign e_window = (cnt_nxt >= lcd_pkg::E_SETUP_CYC) &&
		(cnt_nxt < lcd_pkg::E_SETUP_CYC + lcd_pkg::E_HIGH_CYC);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else if (!active) begin
			cnt <= '0;
			e   <= 1'b0;
			if (start) begin
				active   <= 1'b1;
				rs       <= rs_in;      // pins driven from cycle 0
				rw       <= rw_in;
				lcd_data <= data_in;
			end
		end else if (done) begin
			active   <= 1'b0;           // pins back to idle
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
		end else begin
			cnt <= cnt_nxt;
			e   <= e_window;
		end
	end

	always_ff @(posedge clk) begin
		if (start && !active) begin
			dur_q <= dur;
		end
	end

endmodule

// ==== source/lcd_init_seq.sv ====
`timescale 1ns/1ps

module lcd_init_seq (
	input  logic               clk,
	input  logic               rst_n,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               done,
	output logic               cmd_req,
	output lcd_pkg::lcd_byte_t cmd_byte,
	output lcd_pkg::cyc_t      cmd_dur,
	output logic               init_done
);

	lcd_pkg::init_step_t step;
	lcd_pkg::init_step_t step_next;
	lcd_pkg::cyc_t       wait_cnt;      // power-up wait
	logic                issued;        // request of this step sent
	logic                cmd_step;      // step that drives a command
	lcd_pkg::lcd_byte_t  step_byte;
	lcd_pkg::cyc_t       step_dur;

	// command byte, length and successor of each step
	always_comb begin
		step_byte = '0;
		step_dur  = '0;
		cmd_step  = 1'b1;
		case (step)
			lcd_pkg::INIT_POWER: begin
				cmd_step  = 1'b0;
				step_next = lcd_pkg::INIT_FSET;
			end
			lcd_pkg::INIT_FSET: begin
				step_byte = {4'b0011, cfg[lcd_pkg::CFG_LINES], cfg[lcd_pkg::CFG_FONT], 2'b00};
				step_dur  = lcd_pkg::FSET_CYC;
				step_next = lcd_pkg::INIT_DISP;
			end
			lcd_pkg::INIT_DISP: begin
				step_byte = {5'b00001, cfg[lcd_pkg::CFG_DISP], cfg[lcd_pkg::CFG_CURS],
					cfg[lcd_pkg::CFG_BLINK]};
				step_dur  = lcd_pkg::DISP_CYC;
				step_next = lcd_pkg::INIT_CLEAR;
			end
			lcd_pkg::INIT_CLEAR: begin
				step_byte = 8'b0000_0001;
				step_dur  = lcd_pkg::CLEAR_CYC;
				step_next = lcd_pkg::INIT_ENTRY;
			end
			lcd_pkg::INIT_ENTRY: begin
				step_byte = {6'b000001, cfg[lcd_pkg::CFG_INC], cfg[lcd_pkg::CFG_SHIFT]};
				step_dur  = lcd_pkg::ENTRY_CYC;
				step_next = lcd_pkg::INIT_DONE;
			end
			default: begin
				cmd_step  = 1'b0;
				step_next = lcd_pkg::INIT_DONE;     // stays here until reset
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step      <= lcd_pkg::INIT_POWER;
			wait_cnt  <= '0;
			issued    <= 1'b0;
			cmd_req   <= 1'b0;
			init_done <= 1'b0;
		end else begin
			cmd_req <= 1'b0;
			if (step == lcd_pkg::INIT_POWER) begin
				if (wait_cnt == lcd_pkg::POWER_UP_CYC - lcd_pkg::cyc_t'(1)) begin
					wait_cnt <= '0;
					step     <= step_next;
				end else begin
					wait_cnt <= wait_cnt + lcd_pkg::cyc_t'(1);
				end
			end else if (step == lcd_pkg::INIT_DONE) begin
				init_done <= 1'b1;
			end else if (!issued) begin
				cmd_req <= 1'b1;                    // one request per step
				issued  <= 1'b1;
			end else if (done) begin
				issued <= 1'b0;
				step   <= step_next;
			end
		end
	end

	// cfg sampled together with each request
	always_ff @(posedge clk) begin
		if (cmd_step && !issued) begin
			cmd_byte <= step_byte;
			cmd_dur  <= step_dur;
		end
	end

endmodule

// ==== source/lcd_ctrl.sv ====
`timescale 1ns/1ps

module lcd_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  lcd_pkg::lcd_cfg_t  in_data,
	input  logic               lcd_enable,
	input  logic [9:0]         lcd_bus,
	output logic               e,
	output logic               rw,
	output logic               rs,
	output lcd_pkg::lcd_byte_t lcd_data,
	output logic               busy
);

	lcd_pkg::ctrl_state_t state;
	lcd_pkg::ctrl_state_t state_nxt;

	logic               cmd_req;
	lcd_pkg::lcd_byte_t cmd_byte;
	lcd_pkg::cyc_t      cmd_dur;
	logic               init_done;

	logic               accept;         // host strobe taken
	logic               host_start;
	logic               host_rs;
	logic               host_rw;
	lcd_pkg::lcd_byte_t host_data;

	logic               init_phase;
	logic               cyc_start;
	logic               cyc_rs;
	logic               cyc_rw;
	lcd_pkg::lcd_byte_t cyc_data;
	lcd_pkg::cyc_t      cyc_dur;
	logic               cyc_done;

	assign accept = (state == lcd_pkg::ST_READY) && !busy && lcd_enable;

	always_comb begin
		state_nxt = state;
		case (state)
			lcd_pkg::ST_INIT:  if (init_done) state_nxt = lcd_pkg::ST_READY;
			lcd_pkg::ST_READY: if (accept) state_nxt = lcd_pkg::ST_XFER;
			lcd_pkg::ST_XFER:  if (cyc_done) state_nxt = lcd_pkg::ST_READY;
			default:           state_nxt = lcd_pkg::ST_INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= lcd_pkg::ST_INIT;
			busy       <= 1'b1;
			host_start <= 1'b0;
		end else begin
			state      <= state_nxt;
			busy       <= (state_nxt != lcd_pkg::ST_READY);
			host_start <= accept;                   // bus cycle starts next edge
		end
	end

	// host word captured at the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			host_rs   <= lcd_bus[9];
			host_rw   <= lcd_bus[8];
			host_data <= lcd_bus[7:0];
		end
	end

	// one bus-cycle block shared by init and host
	assign init_phase = (state == lcd_pkg::ST_INIT);
	assign cyc_start  = init_phase ? cmd_req  : host_start;
	assign cyc_rs     = init_phase ? 1'b0     : host_rs;
	assign cyc_rw     = init_phase ? 1'b0     : host_rw;
	assign cyc_data   = init_phase ? cmd_byte : host_data;
	assign cyc_dur    = init_phase ? cmd_dur  : lcd_pkg::CMD_CYC;

	lcd_init_seq lcd_init_seq_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (in_data),
		.done      (cyc_done),
		.cmd_req   (cmd_req),
		.cmd_byte  (cmd_byte),
		.cmd_dur   (cmd_dur),
		.init_done (init_done)
	);

	lcd_bus_cycle lcd_bus_cycle_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (cyc_start),
		.rs_in    (cyc_rs),
		.rw_in    (cyc_rw),
		.data_in  (cyc_data),
		.dur      (cyc_dur),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.done     (cyc_done)
	);

endmodule

// ==== testbench/lcd_ctrl_asserts.sv ====
`timescale 1ns/1ps

module lcd_ctrl_asserts (
	input logic               clk,
	input logic               rst_n,
	input logic               e,
	input logic               rs,
	input logic               rw,
	input lcd_pkg::lcd_byte_t lcd_data,
	input logic               busy
);

	// enable pulses only happen inside init or a transfer
	property e_only_when_busy;
		@(posedge clk) disable iff (!rst_n) e |-> busy;
	endproperty

	property pins_stable_in_pulse;
		@(posedge clk) disable iff (!rst_n) e |=> $stable({rs, rw, lcd_data});
	endproperty

	property busy_after_reset;
		@(posedge clk) !rst_n |=> busy;
	endproperty

	assert property (e_only_when_busy)
		else $error("e high while busy is low");
	assert property (pins_stable_in_pulse)
		else $error("rs, rw or lcd_data changed while e high");
	assert property (busy_after_reset)
		else $error("busy low in the cycle after reset");

endmodule

bind lcd_ctrl lcd_ctrl_asserts lcd_ctrl_asserts_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.e        (e),
	.rs       (rs),
	.rw       (rw),
	.lcd_data (lcd_data),
	.busy     (busy)
);

// ==== testbench/lcd_ctrl_tb.sv ====
`timescale 1ns/1ps

module lcd_ctrl_tb;

	localparam int XFER_LIMIT = int'(lcd_pkg::CMD_CYC) + 16;
	localparam int INIT_LIMIT = int'(lcd_pkg::POWER_UP_CYC) + int'(lcd_pkg::FSET_CYC) +
		int'(lcd_pkg::DISP_CYC) + int'(lcd_pkg::CLEAR_CYC) + int'(lcd_pkg::ENTRY_CYC) + 64;

	logic clk;
	logic rst_n;
	lcd_pkg::lcd_cfg_t  in_data;
	logic lcd_enable;
	logic [9:0] lcd_bus;
	logic e;
	logic rw;
	logic rs;
	lcd_pkg::lcd_byte_t lcd_data;
	logic busy;

	int edge_cnt = 0;                   // rising edges since time 0
	logic e_prev = 1'b0;
	int high_len = 0;
	logic mon_rs[$];
	logic mon_rw[$];
	lcd_pkg::lcd_byte_t mon_data[$];
	int mon_rise[$];                    // edge index where e rose
	int mon_len[$];                     // e high time in cycles

	lcd_ctrl lcd_ctrl_i (.clk(clk), .rst_n(rst_n), .in_data(in_data), .lcd_enable(lcd_enable),
		.lcd_bus(lcd_bus), .e(e), .rw(rw), .rs(rs), .lcd_data(lcd_data), .busy(busy));

	always #2 clk = ~clk;

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	// pins are settled by the falling edge
	always @(negedge clk) begin
		if (e && !e_prev) begin
			mon_rs.push_back(rs);
			mon_rw.push_back(rw);
			mon_data.push_back(lcd_data);
			mon_rise.push_back(edge_cnt);
			high_len = 1;
		end else if (e) begin
			high_len++;
		end else if (e_prev) begin
			mon_len.push_back(high_len);
		end
		e_prev = e;
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input lcd_pkg::lcd_byte_t exp,
		input lcd_pkg::lcd_byte_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_cyc(input string name, input lcd_pkg::cyc_t exp,
		input lcd_pkg::cyc_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	// command byte of init step idx in HD44780 instruction layout
	function automatic lcd_pkg::lcd_byte_t init_cmd_byte(input lcd_pkg::lcd_cfg_t cfg,
		input int idx);
		case (idx)
			0:       return {4'b0011, cfg[6], cfg[5], 2'b00};
			1:       return {5'b00001, cfg[4], cfg[3], cfg[2]};
			2:       return 8'h01;
			default: return {6'b000001, cfg[1], cfg[0]};
		endcase
	endfunction

	function automatic logic [9:0] rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[9:0];
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic wait_not_busy(input int limit, output int n);
		n = 0;
		while (busy !== 1'b0) begin
			if (n == limit) begin
				$display("busy did not fall within %0d cycles", limit);
				abort_run();
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic strobe_word(input logic [9:0] word, output int acc_edge);
		int n;
		wait_not_busy(XFER_LIMIT, n);
		lcd_enable = 1'b1;
		lcd_bus    = word;
		next_cycle();                   // accepting edge
		acc_edge   = edge_cnt;
		lcd_enable = 1'b0;
		check_bit("busy", 1'b1, busy);
	endtask

	task automatic check_pulse(input int idx, input logic [9:0] word, input int acc_edge);
		check_bit("rs", word[9], mon_rs[idx]);
		check_bit("rw", word[8], mon_rw[idx]);
		check_byte("lcd_data", word[7:0], mon_data[idx]);
		check_cyc("e rise delay", lcd_pkg::E_SETUP_CYC + lcd_pkg::cyc_t'(1),
			lcd_pkg::cyc_t'(mon_rise[idx] - acc_edge));
		check_cyc("e high time", lcd_pkg::E_HIGH_CYC, lcd_pkg::cyc_t'(mon_len[idx]));
	endtask

	task automatic check_idle_pins();
		check_bit("busy", 1'b1, busy);
		check_bit("e", 1'b0, e);
		check_bit("rs", 1'b0, rs);
		check_bit("rw", 1'b0, rw);
		check_byte("lcd_data", 8'h00, lcd_data);
	endtask

	task automatic test_reset();
		rst_n = 1'b0;
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			check_idle_pins();
		end
		rst_n = 1'b1;
		next_cycle();
		check_idle_pins();
	endtask

	task automatic test_init();
		int n;
		wait_not_busy(INIT_LIMIT, n);
		check_cyc("init pulse count", lcd_pkg::cyc_t'(4), lcd_pkg::cyc_t'(mon_data.size()));
		for (int i = 0; i < 4; i++) begin
			check_byte("init lcd_data", init_cmd_byte(in_data, i), mon_data[i]);
			check_bit("init rs", 1'b0, mon_rs[i]);
			check_bit("init rw", 1'b0, mon_rw[i]);
			check_cyc("init e high time", lcd_pkg::E_HIGH_CYC, lcd_pkg::cyc_t'(mon_len[i]));
		end
	endtask

	task automatic test_write();
		logic [9:0] word;
		int base;
		int acc;
		int n;
		word = rand_word();
		base = mon_data.size();
		strobe_word(word, acc);
		wait_not_busy(XFER_LIMIT, n);
		check_cyc("busy fall delay", lcd_pkg::CMD_CYC + lcd_pkg::cyc_t'(1), lcd_pkg::cyc_t'(n));
		check_cyc("pulse count", lcd_pkg::cyc_t'(base + 1), lcd_pkg::cyc_t'(mon_data.size()));
		check_pulse(base, word, acc);
	endtask

	task automatic test_ignore_busy();
		logic [9:0] word;
		int base;
		int acc;
		int n;
		word = rand_word();
		base = mon_data.size();
		strobe_word(word, acc);
		repeat (20) next_cycle();       // one strobe in setup, one while e high
		for (int k = 0; k < 2; k++) begin
			lcd_enable = 1'b1;
			lcd_bus    = ~word;
			next_cycle();
			lcd_enable = 1'b0;
			repeat (80) next_cycle();
		end
		wait_not_busy(XFER_LIMIT, n);
		repeat (2 * int'(lcd_pkg::E_SETUP_CYC)) begin
			next_cycle();
			check_bit("busy", 1'b0, busy);
			check_bit("e", 1'b0, e);
		end
		check_cyc("pulse count", lcd_pkg::cyc_t'(base + 1), lcd_pkg::cyc_t'(mon_data.size()));
		check_pulse(base, word, acc);
	endtask

	task automatic test_burst();
		logic [9:0] words[8];
		int accs[8];
		int base;
		int n;
		base = mon_data.size();
		for (int i = 0; i < 8; i++) begin
			words[i] = rand_word();
			strobe_word(words[i], accs[i]);
			wait_not_busy(XFER_LIMIT, n);
			check_cyc("busy fall delay", lcd_pkg::CMD_CYC + lcd_pkg::cyc_t'(1),
				lcd_pkg::cyc_t'(n));
		end
		check_cyc("pulse count", lcd_pkg::cyc_t'(base + 8), lcd_pkg::cyc_t'(mon_data.size()));
		for (int i = 0; i < 8; i++) begin
			check_pulse(base + i, words[i], accs[i]);
		end
	endtask

	initial begin
		logic [31:0] r;
		clk        = 1'b0;
		rst_n      = 1'b0;
		lcd_enable = 1'b0;
		lcd_bus    = '0;
		void'($urandom(32'h6e377ff7));
		r          = $urandom;
		in_data    = r[6:0];            // held through init
		test_reset();
		test_init();
		test_write();
		test_ignore_busy();
		test_burst();
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== lcd_ctrl.f ====
source/lcd_pkg.sv
source/lcd_bus_cycle.sv
source/lcd_init_seq.sv
source/lcd_ctrl.sv
testbench/lcd_ctrl_asserts.sv
testbench/lcd_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lcd_ctrl_tb
FILELIST  ?= lcd_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
